// File: fp_format_pkg.sv
// ====================
// binary32 format: field widths, operand record,
// canonical NaN, class record and FCLASS mask width
// ====================

package fp_format_pkg;

  // ====================
  // Field widths
  // ====================
  localparam int EXP_W = 8;                  // Biased exponent
  localparam int MAN_W = 23;                 // Stored fraction, hidden bit not included
  localparam int FP_W  = 1 + EXP_W + MAN_W;  // Whole word, 32 bits

  // One operand or result, sign on top
  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [MAN_W-1:0] man;
  } fp32_t;

  // Quiet NaN with only the top fraction bit set
  localparam fp32_t CANON_NAN = 32'h7FC0_0000;

  // ====================
  // Classification
  // ====================
  // One flag per property, several can be set at once
  // (is_nan together with is_snan or is_qnan)
  typedef struct packed {
    logic is_neg;        // Sign bit set
    logic is_inf;        // Exponent all ones, fraction zero
    logic is_normal;     // Exponent neither zero nor all ones
    logic is_subnormal;  // Exponent zero, fraction nonzero
    logic is_zero;       // Exponent and fraction zero
    logic is_snan;       // NaN with quiet bit clear
    logic is_qnan;       // NaN with quiet bit set
    logic is_nan;        // Either kind of NaN
  } fp_class_t;

  localparam int CLASS_W = 10;  // RISC-V FCLASS result bits

endpackage

// File: fpu_op_pkg.sv
// ====================
// FPU operation set: opcode enum, request record
// and opcode group functions
// ====================

package fpu_op_pkg;
  import fp_format_pkg::*;

  // ====================
  // Opcodes
  // ====================
  // Compares come in already split, no funct3 decoding here
  typedef enum logic [3:0] {
    OP_FSGNJ   = 4'd0,
    OP_FSGNJN  = 4'd1,
    OP_FSGNJX  = 4'd2,
    OP_FMIN    = 4'd3,
    OP_FMAX    = 4'd4,
    OP_FEQ     = 4'd5,
    OP_FLT     = 4'd6,
    OP_FLE     = 4'd7,
    OP_FCLASS  = 4'd8,
    OP_FMV_X_W = 4'd9,   // FP bits to integer register
    OP_FMV_W_X = 4'd10   // Integer bits to FP register
  } fpu_op_e;

  // Request as seen at start, 68 bits
  typedef struct packed {
    fpu_op_e op;
    fp32_t   a;  // rs1
    fp32_t   b;  // rs2
  } fpu_req_t;

  // ====================
  // Opcode groups
  // ====================
  // Ops whose result goes to the integer register file
  function automatic logic is_int_op(fpu_op_e op);
    return op inside {OP_FEQ, OP_FLT, OP_FLE, OP_FCLASS, OP_FMV_X_W};
  endfunction

  function automatic logic is_cmp_op(fpu_op_e op);
    return op inside {OP_FEQ, OP_FLT, OP_FLE};
  endfunction

  function automatic logic is_minmax_op(fpu_op_e op);
    return op inside {OP_FMIN, OP_FMAX};
  endfunction

endpackage

// File: fp_classify.sv
// ====================
// Operand classifier: IEEE class record and
// the ten-bit RISC-V FCLASS mask, purely combinational
// ====================

module fp_classify import fp_format_pkg::*; (
  input  fp32_t               operand,
  output fp_class_t           cls,
  output logic [CLASS_W-1:0]  class_mask
);

  logic exp_ones;   // Exponent all ones, inf or NaN
  logic exp_zero;   // Exponent zero, zero or subnormal
  logic man_zero;
  logic quiet_bit;  // Top fraction bit

  assign exp_ones  = &operand.exp;
  assign exp_zero  = ~|operand.exp;
  assign man_zero  = ~|operand.man;
  assign quiet_bit = operand.man[MAN_W-1];

  // ====================
  // Class record
  // ====================
  assign cls.is_neg       = operand.sign;
  assign cls.is_inf       = exp_ones & man_zero;
  assign cls.is_nan       = exp_ones & ~man_zero;
  assign cls.is_qnan      = exp_ones & ~man_zero & quiet_bit;
  assign cls.is_snan      = exp_ones & ~man_zero & ~quiet_bit;
  assign cls.is_zero      = exp_zero & man_zero;
  assign cls.is_subnormal = exp_zero & ~man_zero;
  assign cls.is_normal    = ~exp_zero & ~exp_ones;

  // ====================
  // FCLASS mask
  // ====================
  // Exactly one bit set for any input
  // NaN bits ignore the sign
  always_comb begin
    class_mask    = '0;
    class_mask[0] = cls.is_neg & cls.is_inf;        // -inf
    class_mask[1] = cls.is_neg & cls.is_normal;     // -normal
    class_mask[2] = cls.is_neg & cls.is_subnormal;  // -subnormal
    class_mask[3] = cls.is_neg & cls.is_zero;       // -0
    class_mask[4] = ~cls.is_neg & cls.is_zero;      // +0
    class_mask[5] = ~cls.is_neg & cls.is_subnormal; // +subnormal
    class_mask[6] = ~cls.is_neg & cls.is_normal;    // +normal
    class_mask[7] = ~cls.is_neg & cls.is_inf;       // +inf
    class_mask[8] = cls.is_snan;                    // Signalling NaN
    class_mask[9] = cls.is_qnan;                    // Quiet NaN
  end

endmodule

// File: fp_compare_minmax.sv
// ====================
// Comparator for FEQ/FLT/FLE and FMIN/FMAX,
// with the invalid flag for both groups
// ====================

module fp_compare_minmax
  import fp_format_pkg::*;
  import fpu_op_pkg::*;
(
  input  fp32_t      a,
  input  fp32_t      b,
  input  fp_class_t  cls_a,
  input  fp_class_t  cls_b,
  input  fpu_op_e    op,
  output logic       cmp_bit,       // Compare result, zero for non-compare ops
  output fp32_t      minmax_value,  // Min or max by op
  output logic       cmp_nv         // Invalid operation
);

  logic [EXP_W+MAN_W-1:0] mag_a;  // Magnitudes without sign
  logic [EXP_W+MAN_W-1:0] mag_b;
  logic mag_lt;
  logic mag_eq;
  logic raw_lt;     // Sign-magnitude order, -0 below +0
  logic raw_eq;
  logic both_zero;
  logic ord_lt;     // IEEE compare order, -0 equal to +0
  logic ord_eq;
  logic any_nan;
  logic any_snan;
  logic is_max;

  // ====================
  // Ordering
  // ====================
  assign mag_a  = {a.exp, a.man};
  assign mag_b  = {b.exp, b.man};
  assign mag_lt = mag_a < mag_b;
  assign mag_eq = mag_a == mag_b;

  // Exponent then fraction orders magnitudes, sign flips it
  always_comb begin
    if (a.sign != b.sign)
      raw_lt = a.sign;                // Negative below positive
    else if (!a.sign)
      raw_lt = mag_lt;                // Both positive
    else
      raw_lt = ~mag_lt & ~mag_eq;     // Both negative, larger magnitude is lower
  end

  assign raw_eq    = (a.sign == b.sign) & mag_eq;
  assign both_zero = cls_a.is_zero & cls_b.is_zero;

  // Compares treat the two zeros as one value
  assign ord_eq = raw_eq | both_zero;
  assign ord_lt = raw_lt & ~both_zero;

  assign any_nan  = cls_a.is_nan | cls_b.is_nan;
  assign any_snan = cls_a.is_snan | cls_b.is_snan;

  // ====================
  // Compare result
  // ====================
  // Unordered inputs make every compare false
  always_comb begin
    cmp_bit = 1'b0;
    if (is_cmp_op(op) && !any_nan) begin
      case (op)
        OP_FEQ:  cmp_bit = ord_eq;
        OP_FLT:  cmp_bit = ord_lt;
        default: cmp_bit = ord_lt | ord_eq;  // FLE
      endcase
    end
  end

  // ====================
  // Invalid flag
  // ====================
  // FEQ is quiet, FLT and FLE signal on any NaN
  always_comb begin
    if (is_cmp_op(op))
      cmp_nv = (op == OP_FEQ) ? any_snan : any_nan;
    else
      cmp_nv = is_minmax_op(op) & any_snan;  // Min/max signal on sNaN only
  end

  // ====================
  // Min/max
  // ====================
  assign is_max = op == OP_FMAX;

  always_comb begin
    if (cls_a.is_nan && cls_b.is_nan)
      minmax_value = CANON_NAN;
    else if (cls_a.is_nan)
      minmax_value = b;             // A lone NaN loses
    else if (cls_b.is_nan)
      minmax_value = a;
    else if (is_max)
      minmax_value = raw_lt ? b : a;
    else
      minmax_value = raw_lt ? a : b;
  end

endmodule

// File: fpu_result_stage.sv
// ====================
// Result stage: opcode mux with sign injection and
// bit moves, output registers for results, flag and done
// ====================

module fpu_result_stage
  import fp_format_pkg::*;
  import fpu_op_pkg::*;
#(
  parameter int XLEN = 32  // 32 or 64
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  fpu_req_t            req,
  input  logic [XLEN-1:0]     int_operand,
  input  logic [CLASS_W-1:0]  class_mask,    // Class of operand a
  input  logic                cmp_bit,
  input  fp32_t               minmax_value,
  input  logic                cmp_nv,
  output logic                done,
  output fp32_t               fp_result,
  output logic [XLEN-1:0]     int_result,
  output logic                flag_nv
);

  logic            inj_sign;   // Sign for FSGNJ*
  logic [FP_W-1:0] word_next;  // 32-bit result before routing
  logic            sext_next;  // Upper integer bits, set only by FMV.X.W
  logic            nv_next;
  logic [XLEN-1:0] int_next;
  fp32_t           fp_next;

  // ====================
  // Sign injection
  // ====================
  always_comb begin
    case (req.op)
      OP_FSGNJN: inj_sign = ~req.b.sign;
      OP_FSGNJX: inj_sign = req.a.sign ^ req.b.sign;
      default:   inj_sign = req.b.sign;  // FSGNJ
    endcase
  end

  // ====================
  // Result mux
  // ====================
  always_comb begin
    word_next = '0;
    sext_next = 1'b0;
    nv_next   = 1'b0;
    case (req.op)
      OP_FSGNJ, OP_FSGNJN, OP_FSGNJX:
        word_next = {inj_sign, req.a.exp, req.a.man};  // Never signals
      OP_FMIN, OP_FMAX: begin
        word_next = minmax_value;
        nv_next   = cmp_nv;
      end
      OP_FEQ, OP_FLT, OP_FLE: begin
        word_next = FP_W'(cmp_bit);
        nv_next   = cmp_nv;
      end
      OP_FCLASS:
        word_next = FP_W'(class_mask);
      OP_FMV_X_W: begin
        word_next = req.a;
        sext_next = req.a.sign;
      end
      OP_FMV_W_X:
        word_next = int_operand[FP_W-1:0];  // Low word only
      default:
        word_next = '0;
    endcase
  end

  // Integer ops write int_result, the rest write fp_result
  // Shift gives nothing when XLEN is 32
  assign int_next = is_int_op(req.op) ?
                    (XLEN'(word_next) | ({XLEN{sext_next}} << FP_W)) : '0;
  assign fp_next  = is_int_op(req.op) ? '0 : fp32_t'(word_next);

  // ====================
  // Output registers
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      done       <= 1'b0;
      fp_result  <= '0;
      int_result <= '0;
      flag_nv    <= 1'b0;
    end else begin
      done <= start;               // One cycle after accept
      if (start) begin             // Hold until next request completes
        fp_result  <= fp_next;
        int_result <= int_next;
        flag_nv    <= nv_next;
      end
    end
  end

endmodule

// File: rv_fpu_s.sv
// ====================
// Single-precision FPU top: two classifiers,
// comparator and registered result stage
// ====================

module rv_fpu_s
  import fp_format_pkg::*;
  import fpu_op_pkg::*;
#(
  parameter int XLEN = 32  // Width of integer operand and result
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,        // Accept req this edge
  input  fpu_req_t         req,
  input  logic [XLEN-1:0]  int_operand,  // Source for FMV.W.X
  output logic             done,         // One-cycle pulse after start
  output fp32_t            fp_result,
  output logic [XLEN-1:0]  int_result,
  output logic             flag_nv
);

  fp_class_t          cls_a;
  fp_class_t          cls_b;
  logic [CLASS_W-1:0] mask_a;  // FCLASS reads rs1 only
  logic               cmp_bit;
  fp32_t              minmax_value;
  logic               cmp_nv;

  // ====================
  // Combinational front
  // ====================
  fp_classify u_class_a (.operand(req.a), .cls(cls_a), .class_mask(mask_a));
  fp_classify u_class_b (.operand(req.b), .cls(cls_b), .class_mask());

  fp_compare_minmax u_cmp (
    .a(req.a), .b(req.b), .cls_a(cls_a), .cls_b(cls_b), .op(req.op),
    .cmp_bit(cmp_bit), .minmax_value(minmax_value), .cmp_nv(cmp_nv)
  );

  // Registered back end
  fpu_result_stage #(.XLEN(XLEN)) u_result (
    .clk(clk), .rst(rst), .start(start), .req(req), .int_operand(int_operand),
    .class_mask(mask_a), .cmp_bit(cmp_bit), .minmax_value(minmax_value),
    .cmp_nv(cmp_nv), .done(done), .fp_result(fp_result),
    .int_result(int_result), .flag_nv(flag_nv)
  );

endmodule

// File: rv_fpu_s_assertions.sv
// ====================
// Bound checker for rv_fpu_s covering done timing,
// done during reset and the invalid flag rule
// ====================

module rv_fpu_s_assertions
  import fpu_op_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     start,
  input fpu_req_t req,
  input logic     done,
  input logic     flag_nv
);
  timeunit 1ns;
  timeprecision 1ps;

  int   error_count = 0;  // Assertion failures so far
  logic nv_allowed;       // Request may raise invalid
  assign nv_allowed = is_cmp_op(req.op) | is_minmax_op(req.op);

  // One cycle from accept to done
  done_follows_start: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> done == $past(start))
    else begin
      error_count++;
      $error("done is not start delayed by one cycle");
    end

  done_low_in_reset: assert property (@(posedge clk) rst |=> !done)
    else begin
      error_count++;
      $error("done high during or right after reset");
    end

  nv_after_cmp_only: assert property (@(posedge clk) disable iff (rst)
    (done && flag_nv) |-> $past(nv_allowed))
    else begin
      error_count++;
      $error("flag_nv set after an op that cannot signal");
    end

endmodule

bind rv_fpu_s rv_fpu_s_assertions u_assertions (
  .clk(clk), .rst(rst), .start(start), .req(req), .done(done), .flag_nv(flag_nv)
);

// File: rv_fpu_s_vectors.svh
// ====================
// Directed vectors for the FPU testbench:
// sign injection, min/max, compares, FCLASS, bit moves
// ====================

`ifndef RV_FPU_S_VECTORS_SVH
`define RV_FPU_S_VECTORS_SVH

  // Columns: op, a, b, int_operand, expected fp_result, expected int_result, expected flag_nv
  task automatic load_vectors();
    // Sign injection on zeros, infinities and ones
    add_vec(OP_FSGNJ,  32'h00000000, 32'h80000000, 64'h0, 32'h80000000, 64'h0, 1'b0);
    add_vec(OP_FSGNJN, 32'h7F800000, 32'h80000000, 64'h0, 32'h7F800000, 64'h0, 1'b0);
    add_vec(OP_FSGNJX, 32'hFF800000, 32'h80000000, 64'h0, 32'h7F800000, 64'h0, 1'b0);
    add_vec(OP_FSGNJX, 32'h3F800000, 32'hBF800000, 64'h0, 32'hBF800000, 64'h0, 1'b0);

    // ====================
    // Min/max
    // ====================
    add_vec(OP_FMIN, 32'h3F800000, 32'h40000000, 64'h0, 32'h3F800000, 64'h0, 1'b0);
    add_vec(OP_FMAX, 32'h3F800000, 32'h40000000, 64'h0, 32'h40000000, 64'h0, 1'b0);
    add_vec(OP_FMIN, 32'hBF800000, 32'hC0000000, 64'h0, 32'hC0000000, 64'h0, 1'b0);
    add_vec(OP_FMAX, 32'hBF800000, 32'hC0000000, 64'h0, 32'hBF800000, 64'h0, 1'b0);
    add_vec(OP_FMIN, 32'h00000000, 32'h80000000, 64'h0, 32'h80000000, 64'h0, 1'b0);  // -0 wins
    add_vec(OP_FMAX, 32'h80000000, 32'h00000000, 64'h0, 32'h00000000, 64'h0, 1'b0);  // +0 wins
    add_vec(OP_FMIN, 32'h7FC00000, 32'h3F800000, 64'h0, 32'h3F800000, 64'h0, 1'b0);  // One qNaN
    add_vec(OP_FMAX, 32'h3F800000, 32'h7FC00001, 64'h0, 32'h3F800000, 64'h0, 1'b0);
    add_vec(OP_FMIN, 32'h7FC00001, 32'hFFC00000, 64'h0, 32'h7FC00000, 64'h0, 1'b0);  // Two NaNs
    add_vec(OP_FMAX, 32'h7F800001, 32'h40000000, 64'h0, 32'h40000000, 64'h0, 1'b1);  // sNaN
    add_vec(OP_FMIN, 32'h7FA00000, 32'hFF800001, 64'h0, 32'h7FC00000, 64'h0, 1'b1);

    // ====================
    // Compares
    // ====================
    add_vec(OP_FEQ, 32'h3F800000, 32'h3F800000, 64'h0, 32'h0, 64'h1, 1'b0);
    add_vec(OP_FEQ, 32'h3F800000, 32'h40000000, 64'h0, 32'h0, 64'h0, 1'b0);
    add_vec(OP_FEQ, 32'h80000000, 32'h00000000, 64'h0, 32'h0, 64'h1, 1'b0);  // -0 == +0
    add_vec(OP_FLT, 32'h3F800000, 32'h40000000, 64'h0, 32'h0, 64'h1, 1'b0);
    add_vec(OP_FLT, 32'h40000000, 32'h3F800000, 64'h0, 32'h0, 64'h0, 1'b0);
    add_vec(OP_FLT, 32'hC0000000, 32'hBF800000, 64'h0, 32'h0, 64'h1, 1'b0);
    add_vec(OP_FLT, 32'h80000000, 32'h00000000, 64'h0, 32'h0, 64'h0, 1'b0);
    add_vec(OP_FLE, 32'h40000000, 32'h40000000, 64'h0, 32'h0, 64'h1, 1'b0);
    add_vec(OP_FLE, 32'h40000000, 32'h3F800000, 64'h0, 32'h0, 64'h0, 1'b0);
    add_vec(OP_FEQ, 32'h7FC00000, 32'h3F800000, 64'h0, 32'h0, 64'h0, 1'b0);  // Quiet on qNaN
    add_vec(OP_FEQ, 32'h7F800001, 32'h3F800000, 64'h0, 32'h0, 64'h0, 1'b1);
    add_vec(OP_FLT, 32'h7FC00000, 32'h3F800000, 64'h0, 32'h0, 64'h0, 1'b1);  // Signals on qNaN
    add_vec(OP_FLE, 32'h3F800000, 32'h7FC00000, 64'h0, 32'h0, 64'h0, 1'b1);

    // FCLASS, one value per class in mask order
    add_vec(OP_FCLASS, 32'hFF800000, 32'h0, 64'h0, 32'h0, 64'h001, 1'b0);
    add_vec(OP_FCLASS, 32'hBF800000, 32'h0, 64'h0, 32'h0, 64'h002, 1'b0);
    add_vec(OP_FCLASS, 32'h80000001, 32'h0, 64'h0, 32'h0, 64'h004, 1'b0);
    add_vec(OP_FCLASS, 32'h80000000, 32'h0, 64'h0, 32'h0, 64'h008, 1'b0);
    add_vec(OP_FCLASS, 32'h00000000, 32'h0, 64'h0, 32'h0, 64'h010, 1'b0);
    add_vec(OP_FCLASS, 32'h00400000, 32'h0, 64'h0, 32'h0, 64'h020, 1'b0);
    add_vec(OP_FCLASS, 32'h3F800000, 32'h0, 64'h0, 32'h0, 64'h040, 1'b0);
    add_vec(OP_FCLASS, 32'h7F800000, 32'h0, 64'h0, 32'h0, 64'h080, 1'b0);
    add_vec(OP_FCLASS, 32'h7F800001, 32'h0, 64'h0, 32'h0, 64'h100, 1'b0);
    add_vec(OP_FCLASS, 32'h7FC00000, 32'h0, 64'h0, 32'h0, 64'h200, 1'b0);

    // Bit moves, sign extension visible at XLEN 64
    add_vec(OP_FMV_X_W, 32'h80000001, 32'h0, 64'h0, 32'h0, 64'hFFFFFFFF80000001, 1'b0);
    add_vec(OP_FMV_X_W, 32'h3F800000, 32'h0, 64'h0, 32'h0, 64'h000000003F800000, 1'b0);
    add_vec(OP_FMV_W_X, 32'h0, 32'h0, 64'hDEADBEEF12345678, 32'h12345678, 64'h0, 1'b0);
  endtask

`endif

// File: rv_fpu_s_tb.sv
// ====================
// FPU testbench with clock and reset, directed table,
// random sign-injection and bit-move stream and watchdog
// ====================

module rv_fpu_s_tb
  import fp_format_pkg::*;
  import fpu_op_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int XLEN       = 64;  // Shows FMV.X.W sign extension
  localparam int CLK_PERIOD = 40;
  localparam int NUM_RANDOM = 64;

  // One request with its expected response
  typedef struct packed {
    fpu_op_e         op;
    fp32_t           a;
    fp32_t           b;
    logic [XLEN-1:0] int_operand;
    fp32_t           exp_fp;
    logic [XLEN-1:0] exp_int;
    logic            exp_nv;
  } vec_t;

  logic            clk;
  logic            rst;
  logic            start;
  fpu_req_t        req;
  logic [XLEN-1:0] int_operand;
  logic            done;
  fp32_t           fp_result;
  logic [XLEN-1:0] int_result;
  logic            flag_nv;

  vec_t        vec_q[$];           // Requests of the current phase
  int          table_len  = 0;     // Directed entries that size the watchdog
  logic [31:0] rng_state  = 32'd80;

  rv_fpu_s #(.XLEN(XLEN)) dut (
    .clk(clk), .rst(rst), .start(start), .req(req), .int_operand(int_operand),
    .done(done), .fp_result(fp_result), .int_result(int_result), .flag_nv(flag_nv)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ====================
  // Helpers
  // ====================
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // Expected result of a sign injection or bit move
  function automatic vec_t model_move(input vec_t v);
    vec_t m;
    m         = v;
    m.exp_fp  = '0;
    m.exp_int = '0;                // Other result stays zero
    m.exp_nv  = 1'b0;              // These ops never signal
    case (v.op)
      OP_FSGNJ:   m.exp_fp = {v.b.sign, v.a.exp, v.a.man};
      OP_FSGNJN:  m.exp_fp = {~v.b.sign, v.a.exp, v.a.man};
      OP_FSGNJX:  m.exp_fp = {v.a.sign ^ v.b.sign, v.a.exp, v.a.man};
      OP_FMV_X_W: m.exp_int = {{(XLEN - 32){v.a.sign}}, v.a};
      OP_FMV_W_X: m.exp_fp = v.int_operand[31:0];
      default:    m.exp_fp = '0;
    endcase
    return m;
  endfunction

  task automatic add_vec(input fpu_op_e op, input logic [31:0] a, input logic [31:0] b,
                         input logic [XLEN-1:0] int_opnd, input logic [31:0] exp_fp,
                         input logic [XLEN-1:0] exp_int, input logic exp_nv);
    vec_t v;
    v.op          = op;
    v.a           = a;
    v.b           = b;
    v.int_operand = int_opnd;
    v.exp_fp      = exp_fp;
    v.exp_int     = exp_int;
    v.exp_nv      = exp_nv;
    vec_q.push_back(v);
  endtask

  `include "rv_fpu_s_vectors.svh"

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("Fail %0t ns: %s got %h expected %h", $time, what, actual, expected);
      $display("Done: errors found");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Back-to-back starts with each result checked in its done cycle
  task automatic run_stream(input string phase);
    vec_t     cur;
    vec_t     prev;
    fpu_req_t req_next;
    for (int i = 0; i <= vec_q.size(); i++) begin
      @(posedge clk);
      if (i < vec_q.size()) begin
        cur          = vec_q[i];
        req_next.op  = cur.op;
        req_next.a   = cur.a;
        req_next.b   = cur.b;
        start       <= 1'b1;
        req         <= req_next;
        int_operand <= cur.int_operand;
      end else begin
        start <= 1'b0;                 // Drain the last request
      end
      if (i > 0) begin
        @(negedge clk);                // Outputs settled mid-cycle
        prev = vec_q[i - 1];
        check(done, 1'b1, $sformatf("%s %0d done", phase, i - 1));
        check(fp_result, prev.exp_fp, $sformatf("%s %0d fp_result", phase, i - 1));
        check(int_result, prev.exp_int, $sformatf("%s %0d int_result", phase, i - 1));
        check(flag_nv, prev.exp_nv, $sformatf("%s %0d flag_nv", phase, i - 1));
      end
    end
  endtask

  task automatic fill_random();
    vec_t v;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      v = '0;
      case (next_random() % 5)
        0:       v.op = OP_FSGNJ;
        1:       v.op = OP_FSGNJN;
        2:       v.op = OP_FSGNJX;
        3:       v.op = OP_FMV_X_W;
        default: v.op = OP_FMV_W_X;
      endcase
      v.a                 = next_random();
      v.b                 = next_random();
      v.int_operand[63:32] = next_random();
      v.int_operand[31:0]  = next_random();
      vec_q.push_back(model_move(v));
    end
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    rst         = 1'b1;
    start       = 1'b0;
    req         = '0;
    int_operand = '0;
    load_vectors();
    table_len = vec_q.size();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);                    // Idle outputs before any start
    check(done, 1'b0, "done after reset");
    check(fp_result, 32'h0, "fp_result after reset");
    check(int_result, 64'h0, "int_result after reset");
    check(flag_nv, 1'b0, "flag_nv after reset");
    run_stream("table");
    vec_q.delete();
    fill_random();
    run_stream("random");
    @(negedge clk);                    // One more edge for done to fall
    if (dut.u_assertions.error_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // Watchdog sized from the table, the random stream and some slack
  initial begin
    wait (table_len > 0);
    #((table_len + NUM_RANDOM + 20) * CLK_PERIOD);
    $display("Timeout: the run did not finish in %0d cycles", table_len + NUM_RANDOM + 20);
    $display("Done: errors found");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: rv_fpu_s.f
+incdir+.
fp_format_pkg.sv
fpu_op_pkg.sv
fp_classify.sv
fp_compare_minmax.sv
fpu_result_stage.sv
rv_fpu_s.sv
rv_fpu_s_assertions.sv
rv_fpu_s_tb.sv

// File: Bender.yml
package:
  name: rv_fpu_s

sources:
  - fp_format_pkg.sv
  - fpu_op_pkg.sv
  - fp_classify.sv
  - fp_compare_minmax.sv
  - fpu_result_stage.sv
  - rv_fpu_s.sv
  - target: test
    include_dirs:
      - .
    files:
      - rv_fpu_s_assertions.sv
      - rv_fpu_s_tb.sv
